/* decode_stage.sv */
module decode_stage
  import rv_core_pkg::*;
  ( input  logic      clk
  , input  logic      reset
  , input  if_to_id_t if_to_id
  , input  logic      wb_we
  , input  reg_idx_t  wb_rd
  , input  data_t     wb_data
  , output id_to_ex_t id_to_ex
  );

  instr_u    instr;
  data_t     imm_i;
  data_t     imm_s;
  data_t     imm_b;
  data_t     imm_u;
  data_t     rs1_val;
  data_t     rs2_val;
  logic      known;
  id_to_ex_t ctrl;

  assign instr = if_to_id.instr;

  // immediate formats
  assign imm_i = {{20{instr.i.imm12[11]}}, instr.i.imm12};
  assign imm_s = {{20{instr.raw[31]}}, instr.raw[31:25], instr.raw[11:7]};
  assign imm_b = {{19{instr.raw[31]}}, instr.raw[31], instr.raw[7], instr.raw[30:25],
                  instr.raw[11:8], 1'b0};
  assign imm_u = {instr.raw[31:12], 12'b0};

  always_comb begin
    ctrl = '0;
    ctrl.alu_op = alu_add;
    known = 1'b1;
    case (instr.r.opcode)
      op_reg: begin
        ctrl.rs1 = instr.r.rs1;
        ctrl.rs2 = instr.r.rs2;
        ctrl.rd = instr.r.rd;
        ctrl.reg_write = 1'b1;
        case (instr.r.funct3)
          3'b000: ctrl.alu_op = instr.r.funct7[5] ? alu_sub : alu_add;
          3'b111: ctrl.alu_op = alu_and;
          3'b110: ctrl.alu_op = alu_or;
          3'b100: ctrl.alu_op = alu_xor;
          3'b010: ctrl.alu_op = alu_slt;
          3'b001: ctrl.alu_op = alu_sll;
          3'b101: ctrl.alu_op = alu_srl;
          default: known = 1'b0;
        endcase
      end
      op_imm: begin
        ctrl.rs1 = instr.i.rs1;
        ctrl.rd = instr.i.rd;
        ctrl.imm = imm_i;
        ctrl.use_imm = 1'b1;
        ctrl.reg_write = 1'b1;
        case (instr.i.funct3)
          3'b000: ctrl.alu_op = alu_add;
          3'b111: ctrl.alu_op = alu_and;
          3'b110: ctrl.alu_op = alu_or;
          3'b100: ctrl.alu_op = alu_xor;
          3'b010: ctrl.alu_op = alu_slt;
          default: known = 1'b0;
        endcase
      end
      op_lui: begin
        ctrl.rd = instr.i.rd;
        ctrl.imm = imm_u;
        ctrl.use_imm = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.alu_op = alu_pass_b;
      end
      op_load: begin
        ctrl.rs1 = instr.i.rs1;
        ctrl.rd = instr.i.rd;
        ctrl.imm = imm_i;
        ctrl.use_imm = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.mem_read = 1'b1;
        known = instr.i.funct3 == 3'b010;
      end
      op_store: begin
        ctrl.rs1 = instr.r.rs1;
        ctrl.rs2 = instr.r.rs2;
        ctrl.imm = imm_s;
        ctrl.use_imm = 1'b1;
        ctrl.mem_write = 1'b1;
        known = instr.r.funct3 == 3'b010;
      end
      op_branch: begin
        ctrl.rs1 = instr.r.rs1;
        ctrl.rs2 = instr.r.rs2;
        ctrl.imm = imm_b;
        ctrl.branch = 1'b1;
        ctrl.branch_ne = instr.r.funct3[0];
        known = instr.r.funct3[2:1] == 2'b00;
      end
      default: known = 1'b0;
    endcase
    // anything outside the subset becomes a bubble
    if (!known) begin
      ctrl = '0;
      ctrl.alu_op = alu_add;
    end
  end

  register_file register_file_inst
    ( .clk     ( clk      )
    , .reset   ( reset    )
    , .rs1     ( ctrl.rs1 )
    , .rs2     ( ctrl.rs2 )
    , .rs1_val ( rs1_val  )
    , .rs2_val ( rs2_val  )
    , .wb_we   ( wb_we    )
    , .wb_rd   ( wb_rd    )
    , .wb_data ( wb_data  )
    );

  always_comb begin
    id_to_ex = ctrl;
    id_to_ex.valid = if_to_id.valid && known;
    id_to_ex.pc = if_to_id.pc;
    id_to_ex.rs1_val = rs1_val;
    id_to_ex.rs2_val = rs2_val;
  end

  unsupported_opcode: assert property (
    @(posedge clk) disable iff (reset)
    if_to_id.valid |-> known
  ) else $error("decode: unsupported instruction %h at pc %h", instr.raw, if_to_id.pc);

endmodule

/* execute_stage.sv */
module execute_stage
  import rv_core_pkg::*;
  ( input  id_to_ex_t  id_to_ex
  , input  fwd_sel_e   fwd_a
  , input  fwd_sel_e   fwd_b
  , input  data_t      wb_data
  , output ex_to_if_t  ex_to_if
  , output ex_to_wb_t  ex_to_wb
  , output addr_t      dmem_address
  , output data_t      dmem_write_data
  , output logic [3:0] dmem_write_enable
  , input  data_t      dmem_read_data
  );

  data_t op_a;
  data_t op_b_reg;
  data_t op_b;
  data_t alu_result;
  logic  operands_equal;

  // forwarded register operands
  assign op_a     = (fwd_a == wb_value) ? wb_data : id_to_ex.rs1_val;
  assign op_b_reg = (fwd_b == wb_value) ? wb_data : id_to_ex.rs2_val;
  assign op_b     = id_to_ex.use_imm ? id_to_ex.imm : op_b_reg;

  always_comb begin
    case (id_to_ex.alu_op)
      alu_add: alu_result = op_a + op_b;
      alu_sub: alu_result = op_a - op_b;
      alu_and: alu_result = op_a & op_b;
      alu_or:  alu_result = op_a | op_b;
      alu_xor: alu_result = op_a ^ op_b;
      alu_slt: alu_result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_sll: alu_result = op_a << op_b[4:0];
      alu_srl: alu_result = op_a >> op_b[4:0];
      default: alu_result = op_b;
    endcase
  end

  // beq and bne compare the register operands, never the immediate
  assign operands_equal = op_a == op_b_reg;

  always_comb begin
    ex_to_if.take_branch = id_to_ex.valid && id_to_ex.branch &&
                           (id_to_ex.branch_ne ? !operands_equal : operands_equal);
    ex_to_if.target = id_to_ex.pc + id_to_ex.imm;
  end

  // data memory, address from the add with the immediate
  assign dmem_address      = alu_result;
  assign dmem_write_data   = op_b_reg;
  assign dmem_write_enable = (id_to_ex.valid && id_to_ex.mem_write) ? 4'b1111 : 4'b0000;

  always_comb begin
    ex_to_wb.valid      = id_to_ex.valid;
    ex_to_wb.rd         = id_to_ex.rd;
    ex_to_wb.reg_write  = id_to_ex.reg_write;
    ex_to_wb.mem_read   = id_to_ex.mem_read;
    ex_to_wb.alu_result = alu_result;
    ex_to_wb.load_data  = dmem_read_data;
  end

  // decode must never hand over a load that also writes memory
  rd_wr_exclusive: assert final (
    !(id_to_ex.valid && id_to_ex.mem_read && dmem_write_enable != 4'b0000)
  ) else $error("execute: memory read and write active together");

endmodule

/* fetch_stage.sv */
module fetch_stage
  import rv_core_pkg::*;
  ( input  logic      clk
  , input  logic      reset
  , input  ex_to_if_t ex_to_if
  , output addr_t     pc
  );

  addr_t pc_next;

  // a taken branch in execute wins over the sequential pc
  always_comb begin
    if (ex_to_if.take_branch) begin
      pc_next = ex_to_if.target;
    end else begin
      pc_next = pc + addr_t'(4);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

  // branch targets come from execute, so a bad immediate would show up here
  pc_aligned: assert property (
    @(posedge clk) disable iff (reset)
    pc[1:0] == 2'b00
  ) else $error("fetch: pc %h is not word aligned", pc);

endmodule

/* hazard_unit.sv */
module hazard_unit
  import rv_core_pkg::*;
  ( input  reg_idx_t ex_rs1
  , input  reg_idx_t ex_rs2
  , input  logic     wb_we
  , input  reg_idx_t wb_rd
  , input  logic     take_branch
  , output fwd_sel_e fwd_a
  , output fwd_sel_e fwd_b
  , output logic     flush_d
  , output logic     flush_e
  );

  // wb_we already covers valid, reg_write and a nonzero rd
  function automatic fwd_sel_e select(reg_idx_t src);
    if (wb_we && wb_rd != '0 && wb_rd == src) begin
      return wb_value;
    end
    return reg_value;
  endfunction

  always_comb begin
    fwd_a = select(ex_rs1);
    fwd_b = select(ex_rs2);
  end

  // squash the two instructions fetched behind a taken branch
  assign flush_d = take_branch;
  assign flush_e = take_branch;

endmodule

/* register_file.sv */
module register_file
  import rv_core_pkg::*;
  ( input  logic     clk
  , input  logic     reset
  , input  reg_idx_t rs1
  , input  reg_idx_t rs2
  , output data_t    rs1_val
  , output data_t    rs2_val
  , input  logic     wb_we
  , input  reg_idx_t wb_rd
  , input  data_t    wb_data
  );

  data_t regs [32];

  // x0 reads zero, a same-cycle write is seen by decode
  function automatic data_t read_port(reg_idx_t idx);
    if (idx == '0) begin
      return '0;
    end
    if (wb_we && idx == wb_rd) begin
      return wb_data;
    end
    return regs[idx];
  endfunction

  always_comb begin
    rs1_val = read_port(rs1);
    rs2_val = read_port(rs2);
  end

  // entry 0 is never written
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_we && wb_rd != '0) begin
      regs[wb_rd] <= wb_data;
    end
  end

endmodule

/* rv_core.f */
+incdir+.
rv_core_pkg.sv
fetch_stage.sv
register_file.sv
decode_stage.sv
execute_stage.sv
write_back.sv
hazard_unit.sv
rv_core.sv
tb_rv_core.sv

/* rv_core.sv */
module rv_core
  import rv_core_pkg::*;
  ( input  logic       clk
  , input  logic       reset
  , output addr_t      imem_address
  , input  data_t      imem_read_data
  , output addr_t      dmem_address
  , output data_t      dmem_write_data
  , output logic [3:0] dmem_write_enable
  , input  data_t      dmem_read_data
  );

  addr_t     pc;
  if_to_id_t if_to_id_next;
  if_to_id_t if_to_id_reg;
  id_to_ex_t id_to_ex_next;
  id_to_ex_t id_to_ex_reg;
  ex_to_wb_t ex_to_wb_next;
  ex_to_wb_t ex_to_wb_reg;
  ex_to_if_t ex_to_if;
  logic      wb_we;
  reg_idx_t  wb_rd;
  data_t     wb_data;
  fwd_sel_e  fwd_a;
  fwd_sel_e  fwd_b;
  logic      flush_d;
  logic      flush_e;

  fetch_stage fetch_stage_inst
    ( .clk      ( clk      )
    , .reset    ( reset    )
    , .ex_to_if ( ex_to_if )
    , .pc       ( pc       )
    );

  assign imem_address = pc;

  always_comb begin
    if_to_id_next.valid     = 1'b1;
    if_to_id_next.pc        = pc;
    if_to_id_next.instr.raw = imem_read_data;
  end

  // reset and a flush turn the entry into a bubble
  always_ff @(posedge clk) begin
    if_to_id_reg <= if_to_id_next;
    if (reset || flush_d) begin
      if_to_id_reg.valid <= 1'b0;
    end
  end

  decode_stage decode_stage_inst
    ( .clk      ( clk           )
    , .reset    ( reset         )
    , .if_to_id ( if_to_id_reg  )
    , .wb_we    ( wb_we         )
    , .wb_rd    ( wb_rd         )
    , .wb_data  ( wb_data       )
    , .id_to_ex ( id_to_ex_next )
    );

  always_ff @(posedge clk) begin
    id_to_ex_reg <= id_to_ex_next;
    if (reset || flush_e) begin
      id_to_ex_reg.valid <= 1'b0;
    end
  end

  execute_stage execute_stage_inst
    ( .id_to_ex          ( id_to_ex_reg      )
    , .fwd_a             ( fwd_a             )
    , .fwd_b             ( fwd_b             )
    , .wb_data           ( wb_data           )
    , .ex_to_if          ( ex_to_if          )
    , .ex_to_wb          ( ex_to_wb_next     )
    , .dmem_address      ( dmem_address      )
    , .dmem_write_data   ( dmem_write_data   )
    , .dmem_write_enable ( dmem_write_enable )
    , .dmem_read_data    ( dmem_read_data    )
    );

  always_ff @(posedge clk) begin
    ex_to_wb_reg <= ex_to_wb_next;
    if (reset) begin
      ex_to_wb_reg.valid <= 1'b0;
    end
  end

  write_back write_back_inst
    ( .clk      ( clk          )
    , .reset    ( reset        )
    , .ex_to_wb ( ex_to_wb_reg )
    , .wb_we    ( wb_we        )
    , .wb_rd    ( wb_rd        )
    , .wb_data  ( wb_data      )
    );

  hazard_unit hazard_unit_inst
    ( .ex_rs1      ( id_to_ex_reg.rs1     )
    , .ex_rs2      ( id_to_ex_reg.rs2     )
    , .wb_we       ( wb_we                )
    , .wb_rd       ( wb_rd                )
    , .take_branch ( ex_to_if.take_branch )
    , .fwd_a       ( fwd_a                )
    , .fwd_b       ( fwd_b                )
    , .flush_d     ( flush_d              )
    , .flush_e     ( flush_e              )
    );

endmodule

/* rv_core_pkg.sv */
package rv_core_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] addr_t;
  typedef logic [xlen-1:0] data_t;
  typedef logic [4:0]      reg_idx_t;

  // major opcodes of the supported subset
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;

  // register-register view
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_fields_t;

  // register-immediate view
  typedef struct packed {
    logic [11:0] imm12;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_fields_t;

  typedef union packed {
    r_fields_t         r;
    i_fields_t         i;
    logic [xlen-1:0]   raw;
  } instr_u;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sll,
    alu_srl,
    alu_pass_b
  } alu_op_e;

  typedef enum logic {
    reg_value,
    wb_value
  } fwd_sel_e;

  typedef struct packed {
    logic   valid;
    addr_t  pc;
    instr_u instr;
  } if_to_id_t;

  typedef struct packed {
    logic     valid;
    addr_t    pc;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    data_t    rs1_val;
    data_t    rs2_val;
    data_t    imm;
    alu_op_e  alu_op;
    logic     use_imm;
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
    logic     branch;
    logic     branch_ne;
  } id_to_ex_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    logic     reg_write;
    logic     mem_read;
    data_t    alu_result;
    data_t    load_data;
  } ex_to_wb_t;

  typedef struct packed {
    logic  take_branch;
    addr_t target;
  } ex_to_if_t;

endpackage

/* tb_rv_core_programs.svh */
task automatic build_programs();
  // random operands land in x1 and x2 through the first four slots
  begin_program("alu_reg_ops", 1'b1);
  emit(rtype_word(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
  emit(rtype_word(7'h20, 3'b000, 5'd4, 5'd1, 5'd2));
  emit(rtype_word(7'h00, 3'b100, 5'd5, 5'd1, 5'd2));
  emit(rtype_word(7'h00, 3'b010, 5'd6, 5'd1, 5'd2));
  emit(store_word(5'd3, 5'd0, 12'h100));
  emit(store_word(5'd4, 5'd0, 12'h104));
  emit(store_word(5'd5, 5'd0, 12'h108));
  emit(store_word(5'd6, 5'd0, 12'h10c));
  expect_result(from_regs, ref_add, 32'h100, '0);
  expect_result(from_regs, ref_sub, 32'h104, '0);
  expect_result(from_regs, ref_xor, 32'h108, '0);
  expect_result(from_regs, ref_slt, 32'h10c, '0);
  end_program();

  begin_program("alu_logic_shift", 1'b1);
  emit(rtype_word(7'h00, 3'b111, 5'd3, 5'd1, 5'd2));
  emit(rtype_word(7'h00, 3'b110, 5'd4, 5'd1, 5'd2));
  emit(rtype_word(7'h00, 3'b001, 5'd5, 5'd1, 5'd2));
  emit(rtype_word(7'h00, 3'b101, 5'd6, 5'd1, 5'd2));
  emit(store_word(5'd3, 5'd0, 12'h110));
  emit(store_word(5'd4, 5'd0, 12'h114));
  emit(store_word(5'd5, 5'd0, 12'h118));
  emit(store_word(5'd6, 5'd0, 12'h11c));
  expect_result(from_regs, ref_and, 32'h110, '0);
  expect_result(from_regs, ref_or, 32'h114, '0);
  expect_result(from_regs, ref_sll, 32'h118, '0);
  expect_result(from_regs, ref_srl, 32'h11c, '0);
  end_program();

  // negative immediates check the sign extension
  begin_program("alu_imm_ops", 1'b1);
  emit(opimm_word(3'b000, 5'd3, 5'd1, 12'hedd));
  emit(opimm_word(3'b111, 5'd4, 5'd1, 12'h7f0));
  emit(opimm_word(3'b110, 5'd5, 5'd1, 12'hff0));
  emit(opimm_word(3'b010, 5'd6, 5'd1, 12'hffb));
  emit(store_word(5'd3, 5'd0, 12'h130));
  emit(store_word(5'd4, 5'd0, 12'h134));
  emit(store_word(5'd5, 5'd0, 12'h138));
  emit(store_word(5'd6, 5'd0, 12'h13c));
  expect_result(from_imm, ref_add, 32'h130, 32'hffff_fedd);
  expect_result(from_imm, ref_and, 32'h134, 32'h0000_07f0);
  expect_result(from_imm, ref_or, 32'h138, 32'hffff_fff0);
  expect_result(from_imm, ref_slt, 32'h13c, 32'hffff_fffb);
  end_program();

  begin_program("dependent_chain", 1'b0);
  emit(opimm_word(3'b000, 5'd1, 5'd0, 12'h005));
  emit(opimm_word(3'b000, 5'd2, 5'd1, 12'h007));
  emit(opimm_word(3'b100, 5'd3, 5'd2, 12'h0f0));
  emit(rtype_word(7'h00, 3'b000, 5'd4, 5'd3, 5'd2));
  emit(store_word(5'd4, 5'd0, 12'h120));
  emit(store_word(5'd3, 5'd0, 12'h124));
  // writer two slots ahead, read through the write-through path
  emit(opimm_word(3'b000, 5'd5, 5'd0, 12'h009));
  emit(nop_word());
  emit(store_word(5'd5, 5'd0, 12'h128));
  expect_value(32'h120, 32'h0000_0108);
  expect_value(32'h124, 32'h0000_00fc);
  expect_value(32'h128, 32'h0000_0009);
  end_program();

  begin_program("load_then_use", 1'b0);
  emit(lui_word(5'd1, 20'h12345));
  emit(opimm_word(3'b000, 5'd1, 5'd1, 12'h678));
  emit(store_word(5'd1, 5'd0, 12'h140));
  emit(load_word(5'd2, 5'd0, 12'h140));
  emit(opimm_word(3'b000, 5'd3, 5'd2, 12'h001));
  emit(store_word(5'd3, 5'd0, 12'h144));
  emit(load_word(5'd4, 5'd0, 12'h144));
  emit(rtype_word(7'h20, 3'b000, 5'd5, 5'd4, 5'd1));
  emit(store_word(5'd5, 5'd0, 12'h148));
  expect_value(32'h140, 32'h1234_5678);
  expect_value(32'h144, 32'h1234_5679);
  expect_value(32'h148, 32'h0000_0001);
  end_program();

  begin_program("branch_flush", 1'b0);
  emit(opimm_word(3'b000, 5'd1, 5'd0, 12'h003));
  emit(opimm_word(3'b000, 5'd2, 5'd0, 12'h003));
  emit(branch_word(3'b000, 5'd1, 5'd2, 13'd12));
  emit(store_word(5'd1, 5'd0, 12'h160));
  emit(store_word(5'd2, 5'd0, 12'h164));
  emit(opimm_word(3'b000, 5'd3, 5'd0, 12'h055));
  emit(store_word(5'd3, 5'd0, 12'h168));
  emit(branch_word(3'b001, 5'd1, 5'd3, 13'd12));
  emit(store_word(5'd1, 5'd0, 12'h16c));
  emit(store_word(5'd1, 5'd0, 12'h170));
  // both of these fall through
  emit(branch_word(3'b000, 5'd1, 5'd3, 13'd8));
  emit(store_word(5'd1, 5'd0, 12'h174));
  emit(branch_word(3'b001, 5'd1, 5'd2, 13'd8));
  emit(store_word(5'd2, 5'd0, 12'h178));
  expect_value(32'h168, 32'h0000_0055);
  expect_value(32'h174, 32'h0000_0003);
  expect_value(32'h178, 32'h0000_0003);
  end_program();

  begin_program("lui_and_x0", 1'b0);
  emit(lui_word(5'd1, 20'hdeadc));
  emit(opimm_word(3'b000, 5'd1, 5'd1, 12'heef));
  emit(store_word(5'd1, 5'd0, 12'h180));
  emit(opimm_word(3'b000, 5'd0, 5'd0, 12'h7ff));
  emit(rtype_word(7'h00, 3'b000, 5'd0, 5'd1, 5'd1));
  emit(store_word(5'd0, 5'd0, 12'h184));
  emit(store_word(5'd1, 5'd0, 12'h188));
  expect_value(32'h180, 32'hdead_beef);
  expect_value(32'h184, 32'h0000_0000);
  expect_value(32'h188, 32'hdead_beef);
  end_program();
endtask

/* tb_rv_core.sv */
module tb_rv_core
  import rv_core_pkg::*;
  ();

  typedef enum logic [1:0] {
    from_table,
    from_regs,
    from_imm
  } expect_src_e;

  typedef enum logic [3:0] {
    ref_add,
    ref_sub,
    ref_and,
    ref_or,
    ref_xor,
    ref_slt,
    ref_sll,
    ref_srl
  } ref_op_e;

  typedef struct packed {
    expect_src_e src;
    ref_op_e     op;
    addr_t       address;
    data_t       value;
  } store_spec_t;

  typedef struct packed {
    logic              random_operands;
    int                instr_count;
    int                store_count;
    data_t [15:0]      instr;
    store_spec_t [3:0] stores;
  } program_t;

  logic        clk = 1'b0;
  logic        reset;
  addr_t       imem_address;
  data_t       imem_read_data;
  addr_t       dmem_address;
  data_t       dmem_write_data;
  logic [3:0]  dmem_write_enable;
  data_t       dmem_read_data;

  data_t       imem [16];
  data_t       dmem [256];
  program_t    programs [$];
  string       program_names [$];
  program_t    building;
  logic        table_built = 1'b0;
  addr_t       store_addr [$];
  data_t       store_data [$];
  logic [3:0]  store_enable [$];
  logic [31:0] lfsr_state = 32'h7d54;

  always #2 clk = ~clk;

  rv_core rv_core_inst
    ( .clk               ( clk               )
    , .reset             ( reset             )
    , .imem_address      ( imem_address      )
    , .imem_read_data    ( imem_read_data    )
    , .dmem_address      ( dmem_address      )
    , .dmem_write_data   ( dmem_write_data   )
    , .dmem_write_enable ( dmem_write_enable )
    , .dmem_read_data    ( dmem_read_data    )
    );

  // both memories answer in the same cycle
  assign imem_read_data = imem[imem_address[5:2]];
  assign dmem_read_data = dmem[dmem_address[9:2]];

  // a store in execute is written at the rising edge that ends its cycle
  always @(posedge clk) begin
    if (!reset && dmem_write_enable != 4'b0000) begin
      store_addr.push_back(dmem_address);
      store_data.push_back(dmem_write_data);
      store_enable.push_back(dmem_write_enable);
      dmem[dmem_address[9:2]] <= dmem_write_data;
    end
  end

  // instruction encodings from the RV32I base formats
  function automatic data_t rtype_word(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
                                       reg_idx_t rs1, reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic data_t opimm_word(logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1,
                                       logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic data_t load_word(reg_idx_t rd, reg_idx_t rs1, logic [11:0] off);
    return {off, rs1, 3'b010, rd, 7'b0000011};
  endfunction

  function automatic data_t store_word(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] off);
    return {off[11:5], rs2, rs1, 3'b010, off[4:0], 7'b0100011};
  endfunction

  function automatic data_t branch_word(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
                                        logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic data_t lui_word(reg_idx_t rd, logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic data_t nop_word();
    return opimm_word(3'b000, 5'd0, 5'd0, 12'h000);
  endfunction

  // beq x0, x0, 0
  function automatic data_t halt_word();
    return branch_word(3'b000, 5'd0, 5'd0, 13'd0);
  endfunction

  // upper part for lui so that the signed addi low part lands on v
  function automatic logic [19:0] upper_part(data_t v);
    data_t t;
    t = v + 32'h0000_0800;
    return t[31:12];
  endfunction

  // galois form, taps x^32 + x^22 + x^2 + x + 1
  function automatic logic next_random_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = {1'b0, lfsr_state[31:1]} ^ (out ? 32'h8020_0003 : 32'h0);
    return out;
  endfunction

  function automatic data_t random_word();
    data_t w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      w = {w[30:0], next_random_bit()};
    end
    return w;
  endfunction

  function automatic data_t reference_result(ref_op_e op, data_t a, data_t b);
    case (op)
      ref_add: return a + b;
      ref_sub: return a - b;
      ref_and: return a & b;
      ref_or:  return a | b;
      ref_xor: return a ^ b;
      ref_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ref_sll: return a << b[4:0];
      default: return a >> b[4:0];
    endcase
  endfunction

  function automatic data_t expected_data(store_spec_t s, data_t a, data_t b);
    case (s.src)
      from_regs: return reference_result(s.op, a, b);
      from_imm:  return reference_result(s.op, a, s.value);
      default:   return s.value;
    endcase
  endfunction

  // slots 0 to 3 of a random entry become lui/addi pairs for x1 and x2
  function automatic data_t program_word(program_t p, int i, data_t a, data_t b);
    if (i >= p.instr_count) begin
      return nop_word();
    end else if (p.random_operands && i == 0) begin
      return lui_word(5'd1, upper_part(a));
    end else if (p.random_operands && i == 1) begin
      return opimm_word(3'b000, 5'd1, 5'd1, a[11:0]);
    end else if (p.random_operands && i == 2) begin
      return lui_word(5'd2, upper_part(b));
    end else if (p.random_operands && i == 3) begin
      return opimm_word(3'b000, 5'd2, 5'd2, b[11:0]);
    end
    return p.instr[i];
  endfunction

  task automatic emit(data_t word);
    building.instr[building.instr_count] = word;
    building.instr_count++;
  endtask

  task automatic begin_program(string name, logic random_operands);
    program_names.push_back(name);
    building = '0;
    building.random_operands = random_operands;
    if (random_operands) begin
      repeat (4) emit(nop_word());
    end
  endtask

  task automatic expect_result(expect_src_e src, ref_op_e op, addr_t address, data_t imm);
    building.stores[building.store_count] = '{src: src, op: op, address: address, value: imm};
    building.store_count++;
  endtask

  task automatic expect_value(addr_t address, data_t value);
    expect_result(from_table, ref_add, address, value);
  endtask

  task automatic end_program();
    emit(halt_word());
    programs.push_back(building);
  endtask

  `include "tb_rv_core_programs.svh"

  task automatic check_store(string name, int idx, addr_t exp_addr, data_t exp_data,
                             addr_t act_addr, data_t act_data);
    if (act_addr !== exp_addr || act_data !== exp_data) begin
      $display("** Error %s store %0d: expected [%h] = %h, actual [%h] = %h",
               name, idx, exp_addr, exp_data, act_addr, act_data);
      $display("Simulation FAILED");
      $fatal(1, "store mismatch");
    end
  endtask

  task automatic check_write_enable(string name, int idx, logic [3:0] exp_we,
                                    logic [3:0] act_we);
    if (act_we !== exp_we) begin
      $display("** Error %s store %0d write enable: expected %b, actual %b",
               name, idx, exp_we, act_we);
      $display("Simulation FAILED");
      $fatal(1, "write enable mismatch");
    end
  endtask

  task automatic check_store_count(string name, int exp_count, int act_count);
    if (act_count != exp_count) begin
      $display("** Error %s store count: expected %0d, actual %0d",
               name, exp_count, act_count);
      $display("Simulation FAILED");
      $fatal(1, "store count mismatch");
    end
  endtask

  task automatic run_program(int n);
    program_t p;
    string    name;
    data_t    a;
    data_t    b;
    p = programs[n];
    name = program_names[n];
    a = random_word();
    b = random_word();
    @(posedge clk);
    reset <= 1'b1;
    for (int i = 0; i < 16; i++) begin
      imem[i] <= program_word(p, i, a, b);
    end
    repeat (8) @(posedge clk);
    store_addr.delete();
    store_data.delete();
    store_enable.delete();
    reset <= 1'b0;
    for (int k = 0; k < p.store_count; k++) begin
      while (store_addr.size() <= k) begin
        @(negedge clk);
      end
      check_store(name, k, p.stores[k].address, expected_data(p.stores[k], a, b),
                  store_addr[k], store_data[k]);
      check_write_enable(name, k, 4'b1111, store_enable[k]);
    end
    // the self loop must not let any further store through
    repeat (10) @(negedge clk);
    check_store_count(name, p.store_count, store_addr.size());
  endtask

  initial begin
    reset = 1'b1;
    for (int i = 0; i < 16; i++) begin
      imem[i] = nop_word();
    end
    for (int i = 0; i < 256; i++) begin
      dmem[i] = 32'hd00d_0000 ^ data_t'(i << 2);
    end
    build_programs();
    table_built = 1'b1;
    for (int n = 0; n < programs.size(); n++) begin
      run_program(n);
    end
    $display("Simulation PASSED");
    $finish;
  end

  initial begin
    wait (table_built);
    repeat (64 * programs.size()) @(posedge clk);
    $display("watchdog: the core stopped producing stores before all programs finished");
    $display("Simulation FAILED");
    $fatal(1, "timeout");
  end

endmodule

/* write_back.sv */
module write_back
  import rv_core_pkg::*;
  ( input  logic      clk
  , input  logic      reset
  , input  ex_to_wb_t ex_to_wb
  , output logic      wb_we
  , output reg_idx_t  wb_rd
  , output data_t     wb_data
  );

  // load data was captured with the rest of the execute results
  always_comb begin
    if (ex_to_wb.mem_read) begin
      wb_data = ex_to_wb.load_data;
    end else begin
      wb_data = ex_to_wb.alu_result;
    end
  end

  assign wb_rd = ex_to_wb.rd;

  // no write for bubbles or writes to x0
  assign wb_we = ex_to_wb.valid && ex_to_wb.reg_write && ex_to_wb.rd != '0;

  // a register write must never carry unknown data
  known_write_data: assert property (
    @(posedge clk) disable iff (reset)
    wb_we |-> !$isunknown(wb_data)
  ) else $error("write back: unknown data written to x%0d", wb_rd);

endmodule
